//--- verilog/sbox_pkg.sv
package sbox_pkg;

	// Datapath geometry
	localparam int SBOX_LANES = 4;
	localparam int WORD_W = 32;
	localparam int ADDR_W = 2;

	// Register map, word offsets
	localparam logic [ADDR_W-1:0] ADDR_CTRL = 2'd0;
	localparam logic [ADDR_W-1:0] ADDR_DATA = 2'd1;
	localparam logic [ADDR_W-1:0] ADDR_RESULT = 2'd2;
	localparam logic [ADDR_W-1:0] ADDR_STATUS = 2'd3;

	// Substitution direction
	localparam logic MODE_INV = 1'b0;
	localparam logic MODE_FWD = 1'b1;

	// Bit positions inside CTRL and STATUS
	localparam int CTRL_MODE_BIT = 0;
	localparam int STATUS_DONE_BIT = 0;
	localparam int STATUS_BUSY_BIT = 1;

endpackage

//--- verilog/sbox_byte.sv
`timescale 1ns/1ps

module sbox_byte
(
	input  logic       clk,
	input  logic [7:0] din,
	input  logic       mode,
	output logic [7:0] out_fwd,
	output logic [7:0] out_inv
);

	// Tower field GF(((2^2)^2)^2) in normal bases.
	// Products come out in inverted form and are undone at the output mapping.

	function automatic logic [1:0] gf2_sq(input logic [1:0] a);
		return {a[0], a[1]};
	endfunction

	// p and q carry the xor of the two bits of each operand
	function automatic logic [1:0] gf2_nmul(input logic [1:0] a, input logic [1:0] b,
		input logic p, input logic q);
		return ~(a & b) ^ {2{~(p & q)}};
	endfunction

	// Multiply merged with scaling by N
	function automatic logic [1:0] gf2_nmul_scl(input logic [1:0] a, input logic [1:0] b,
		input logic p, input logic q);
		logic [1:0] n;
		n = ~(a & b);
		return {~(p & q) ^ n[0], ^n};
	endfunction

	function automatic logic [3:0] gf4_inv(input logic [3:0] a);
		logic [1:0] hi;
		logic [1:0] lo;
		logic       xh;
		logic       xl;
		logic [1:0] d;
		hi = a[3:2];
		lo = a[1:0];
		xh = ^hi;
		xl = ^lo;
		d = gf2_sq({~(hi[1] | lo[1]) ^ ~(xh & xl), ~(xh | xl) ^ ~(hi[0] & lo[0])});
		return {gf2_nmul(d, lo, ^d, xl), gf2_nmul(d, hi, ^d, xh)};
	endfunction

	function automatic logic [3:0] gf4_nmul(input logic [3:0] a, input logic [3:0] b);
		logic [1:0] sa;
		logic [1:0] sb;
		logic [1:0] ph;
		logic [1:0] pl;
		logic [1:0] ps;
		sa = a[3:2] ^ a[1:0];
		sb = b[3:2] ^ b[1:0];
		ph = gf2_nmul(a[3:2], b[3:2], a[3] ^ a[2], b[3] ^ b[2]);
		pl = gf2_nmul(a[1:0], b[1:0], a[1] ^ a[0], b[1] ^ b[0]);
		ps = gf2_nmul_scl(sa, sb, ^sa, ^sb);
		return {ph ^ ps, pl ^ ps};
	endfunction

	// First half of the GF(2^8) inverse, square-scale plus multiply folded
	// into a single 4-bit result
	function automatic logic [3:0] gf8_inv_front(input logic [7:0] a);
		logic [3:0] h;
		logic [3:0] l;
		logic       c1;
		logic       c2;
		logic       c3;
		h = a[7:4];
		l = a[3:0];
		c1 = ~((h[3] ^ h[2]) & (l[3] ^ l[2]));
		c2 = ~((h[2] ^ h[0]) & (l[2] ^ l[0]));
		c3 = ~((^h) & (^l));
		return {
			~((h[2] ^ h[0]) | (l[2] ^ l[0])) ^ ~(h[3] & l[3]) ^ c1 ^ c3,
			~((h[3] ^ h[1]) | (l[3] ^ l[1])) ^ ~(h[2] & l[2]) ^ c1 ^ c2,
			~((h[1] ^ h[0]) | (l[1] ^ l[0])) ^ ~(h[1] & l[1]) ^ c2 ^ c3,
			~(h[0] | l[0]) ^ ~((h[1] ^ h[0]) & (l[1] ^ l[0]))
				^ ~((h[3] ^ h[1]) & (l[3] ^ l[1])) ^ c2
		};
	endfunction

	// Basis change into the tower field, inverse affine merged in for decryption
	function automatic logic [7:0] map_in(input logic [7:0] b, input logic fwd);
		logic t1, t2, t3, t4, t5, t6, t7, t8, t9;
		t1 = b[7] ^ b[5];
		t2 = b[7] ~^ b[4];
		t3 = b[6] ^ b[0];
		t4 = b[5] ~^ t3;
		t5 = b[4] ^ t4;
		t6 = b[3] ^ b[0];
		t7 = b[2] ^ t1;
		t8 = b[1] ^ t3;
		t9 = b[3] ^ t8;
		if (fwd == sbox_pkg::MODE_FWD)
			return {t7 ~^ t8, t5, b[1] ^ t4, t1 ~^ t3, b[1] ^ t2 ^ t6, ~b[0], t4, b[2] ~^ t9};
		return {t2, b[4] ^ t8, b[6] ^ b[4], t9, b[6] ~^ t2, t7, b[4] ^ t6, b[1] ^ t5};
	endfunction

	// Basis change back, affine merged in for encryption
	function automatic logic [7:0] map_out(input logic [7:0] b, input logic fwd);
		logic u1, u2, u3, u4, u5, u6, u7, u8, u9, u10;
		u1 = b[7] ^ b[3];
		u2 = b[6] ^ b[4];
		u3 = b[6] ^ b[0];
		u4 = b[5] ~^ b[3];
		u5 = b[5] ~^ u1;
		u6 = b[5] ~^ b[1];
		u7 = b[4] ~^ u6;
		u8 = b[2] ^ u4;
		u9 = b[1] ^ u2;
		u10 = u3 ^ u5;
		if (fwd == sbox_pkg::MODE_FWD)
			return {u4, u1, u3, u5, u2 ^ u5, u3 ^ u8, u7, u9};
		return {b[4] ~^ b[1], b[1] ^ u10, b[2] ^ u10, b[6] ~^ b[1], u8 ^ u9,
			b[7] ~^ u7, u6, ~b[2]};
	endfunction

	logic [7:0] base;
	logic [3:0] front;
	logic [7:0] base_q;
	logic [3:0] front_q;
	logic [3:0] inv4;
	logic [7:0] inv8;

	assign base = ~map_in(din, mode);
	assign front = gf8_inv_front(base);

	// Pipeline cut between the two inverse halves
	always_ff @(posedge clk)
	begin
		base_q <= base;
		front_q <= front;
	end

	assign inv4 = gf4_inv(front_q);
	assign inv8 = {gf4_nmul(inv4, base_q[3:0]), gf4_nmul(inv4, base_q[7:4])};

	assign out_fwd = ~map_out(inv8, sbox_pkg::MODE_FWD);
	assign out_inv = ~map_out(inv8, sbox_pkg::MODE_INV);

endmodule

//--- verilog/sbox_word.sv
`timescale 1ns/1ps

module sbox_word
(
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        launch,
	input  logic                        mode,
	input  logic [sbox_pkg::WORD_W-1:0] din,
	output logic [sbox_pkg::WORD_W-1:0] dout,
	output logic                        out_valid
);

	logic                        mode_q;
	logic [sbox_pkg::WORD_W-1:0] fwd_word;
	logic [sbox_pkg::WORD_W-1:0] inv_word;

	for (genvar i = 0; i < sbox_pkg::SBOX_LANES; i++)
	begin : g_lane
		sbox_byte u_lane
		(
			.clk     (clk),
			.din     (din[8*i +: 8]),
			.mode    (mode),
			.out_fwd (fwd_word[8*i +: 8]),
			.out_inv (inv_word[8*i +: 8])
		);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= launch;
	end

	// Mode follows its word through the lane register
	always_ff @(posedge clk)
		mode_q <= mode;

	assign dout = (mode_q == sbox_pkg::MODE_FWD) ? fwd_word : inv_word;

endmodule

//--- verilog/wb_sbox_regs.sv
`timescale 1ns/1ps

module wb_sbox_regs
(
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            cyc,
	input  logic                            stb,
	input  logic                            we,
	input  logic [sbox_pkg::ADDR_W-1:0]     adr,
	input  logic [sbox_pkg::WORD_W-1:0]     dat_w,
	input  logic [sbox_pkg::SBOX_LANES-1:0] sel,
	input  logic [sbox_pkg::WORD_W-1:0]     result,
	input  logic                            done,
	output logic [sbox_pkg::WORD_W-1:0]     dat_r,
	output logic                            ack,
	output logic                            launch,
	output logic [sbox_pkg::WORD_W-1:0]     din,
	output logic                            mode,
	output logic                            busy
);

	logic                        accept;
	logic                        wr_ctrl;
	logic                        wr_data;
	logic                        pending;
	logic [sbox_pkg::WORD_W-1:0] ctrl_word;
	logic [sbox_pkg::WORD_W-1:0] status_word;

	// New request only while no ack is outstanding
	assign accept = cyc && stb && !ack;
	assign wr_ctrl = accept && we && (adr == sbox_pkg::ADDR_CTRL);
	assign wr_data = accept && we && (adr == sbox_pkg::ADDR_DATA);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ack <= 1'b0;
			launch <= 1'b0;
			pending <= 1'b0;
		end
		else
		begin
			ack <= accept;
			launch <= wr_data;
			if (wr_data)
				pending <= 1'b1;
			else if (done && !launch)
				pending <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			mode <= sbox_pkg::MODE_FWD;
			din <= '0;
		end
		else
		begin
			if (wr_ctrl && sel[sbox_pkg::CTRL_MODE_BIT / 8])
				mode <= dat_w[sbox_pkg::CTRL_MODE_BIT];
			for (int i = 0; i < sbox_pkg::SBOX_LANES; i++)
			begin
				if (wr_data && sel[i])
					din[8*i +: 8] <= dat_w[8*i +: 8];
			end
		end
	end

	// Stale done from the previous word is masked during the launch cycle
	assign busy = launch || (pending && !done);

	always_comb
	begin
		ctrl_word = '0;
		ctrl_word[sbox_pkg::CTRL_MODE_BIT] = mode;
		status_word = '0;
		status_word[sbox_pkg::STATUS_DONE_BIT] = done;
		status_word[sbox_pkg::STATUS_BUSY_BIT] = busy;
	end

	always_comb
	begin
		case (adr)
			sbox_pkg::ADDR_CTRL: dat_r = ctrl_word;
			sbox_pkg::ADDR_DATA: dat_r = din;
			sbox_pkg::ADDR_RESULT: dat_r = result;
			sbox_pkg::ADDR_STATUS: dat_r = status_word;
			default: dat_r = '0;
		endcase
	end

endmodule

//--- verilog/sbox_result.sv
`timescale 1ns/1ps

module sbox_result
(
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        launch,
	input  logic                        out_valid,
	input  logic [sbox_pkg::WORD_W-1:0] dout,
	output logic [sbox_pkg::WORD_W-1:0] result,
	output logic                        done
);

	always_ff @(posedge clk)
	begin
		if (reset)
			result <= '0;
		else if (out_valid)
			result <= dout;
	end

	// A launch seen together with out_valid belongs to the next word,
	// so completion takes priority
	always_ff @(posedge clk)
	begin
		if (reset)
			done <= 1'b0;
		else if (out_valid)
			done <= 1'b1;
		else if (launch)
			done <= 1'b0;
	end

endmodule

//--- verilog/sbox_wb_top.sv
`timescale 1ns/1ps

module sbox_wb_top
(
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            cyc,
	input  logic                            stb,
	input  logic                            we,
	input  logic [sbox_pkg::ADDR_W-1:0]     adr,
	input  logic [sbox_pkg::WORD_W-1:0]     dat_w,
	input  logic [sbox_pkg::SBOX_LANES-1:0] sel,
	output logic [sbox_pkg::WORD_W-1:0]     dat_r,
	output logic                            ack
);

	logic                        launch;
	logic                        mode;
	logic [sbox_pkg::WORD_W-1:0] din;
	logic [sbox_pkg::WORD_W-1:0] dout;
	logic                        out_valid;
	logic [sbox_pkg::WORD_W-1:0] result;
	logic                        done;

	wb_sbox_regs u_regs
	(
		.clk    (clk),
		.reset  (reset),
		.cyc    (cyc),
		.stb    (stb),
		.we     (we),
		.adr    (adr),
		.dat_w  (dat_w),
		.sel    (sel),
		.result (result),
		.done   (done),
		.dat_r  (dat_r),
		.ack    (ack),
		.launch (launch),
		.din    (din),
		.mode   (mode),
		.busy   ()
	);

	sbox_word u_word
	(
		.clk       (clk),
		.reset     (reset),
		.launch    (launch),
		.mode      (mode),
		.din       (din),
		.dout      (dout),
		.out_valid (out_valid)
	);

	sbox_result u_result
	(
		.clk       (clk),
		.reset     (reset),
		.launch    (launch),
		.out_valid (out_valid),
		.dout      (dout),
		.result    (result),
		.done      (done)
	);

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock
#(
	parameter int PERIOD = 10,
	parameter int RESET_CYCLES = 16
)
(
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk;
	end

	// Released on a falling edge, away from the sampling edge
	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
	end

endmodule

//--- dv/sbox_tb.sv
`timescale 1ns/1ps

module sbox_tb;

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 16;
	localparam int RANDOM_WORDS = 500;
	localparam int ROUND_TRIPS = 100;
	localparam int ACK_LIMIT = 16;
	localparam int unsigned SEED = 32'hecc650b0;
	// Four bus accesses per transformed word, plus the directed tests
	localparam int TRANSACTIONS = RANDOM_WORDS * 4 + ROUND_TRIPS * 8 + 50;
	localparam int WATCHDOG_CYCLES = TRANSACTIONS * 20 + RESET_CYCLES;
	localparam logic [sbox_pkg::SBOX_LANES-1:0] ALL_LANES = '1;

	logic                            clk;
	logic                            reset;
	logic                            cyc;
	logic                            stb;
	logic                            we;
	logic [sbox_pkg::ADDR_W-1:0]     adr;
	logic [sbox_pkg::WORD_W-1:0]     dat_w;
	logic [sbox_pkg::SBOX_LANES-1:0] sel;
	logic [sbox_pkg::WORD_W-1:0]     dat_r;
	logic                            ack;

	tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock
	(
		.clk   (clk),
		.reset (reset)
	);

	sbox_wb_top u_dut
	(
		.clk   (clk),
		.reset (reset),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.dat_w (dat_w),
		.sel   (sel),
		.dat_r (dat_r),
		.ack   (ack)
	);

	// GF(2^8) product modulo x^8 + x^4 + x^3 + x + 1
	function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
		logic [7:0] p;
		logic [7:0] x;
		p = 8'h00;
		x = a;
		for (int i = 0; i < 8; i++)
		begin
			if (b[i])
				p = p ^ x;
			x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
		end
		return p;
	endfunction

	// a^254 is the inverse and maps zero to zero
	function automatic logic [7:0] gf_inv(input logic [7:0] a);
		logic [7:0] r;
		r = 8'h01;
		for (int i = 0; i < 254; i++)
			r = gf_mul(r, a);
		return r;
	endfunction

	function automatic logic [7:0] rotl(input logic [7:0] x, input int n);
		return (x << n) | (x >> (8 - n));
	endfunction

	function automatic logic [7:0] sbox_fwd(input logic [7:0] a);
		logic [7:0] b;
		b = gf_inv(a);
		return b ^ rotl(b, 1) ^ rotl(b, 2) ^ rotl(b, 3) ^ rotl(b, 4) ^ 8'h63;
	endfunction

	function automatic logic [7:0] sbox_inv(input logic [7:0] a);
		return gf_inv(rotl(a, 1) ^ rotl(a, 3) ^ rotl(a, 6) ^ 8'h05);
	endfunction

	function automatic logic [sbox_pkg::WORD_W-1:0] expect_word(
		input logic [sbox_pkg::WORD_W-1:0] w, input logic mode);
		logic [sbox_pkg::WORD_W-1:0] r;
		for (int i = 0; i < sbox_pkg::SBOX_LANES; i++)
		begin
			if (mode == sbox_pkg::MODE_FWD)
				r[8*i +: 8] = sbox_fwd(w[8*i +: 8]);
			else
				r[8*i +: 8] = sbox_inv(w[8*i +: 8]);
		end
		return r;
	endfunction

	function automatic logic [sbox_pkg::WORD_W-1:0] mode_word(input logic mode);
		logic [sbox_pkg::WORD_W-1:0] c;
		c = '0;
		c[sbox_pkg::CTRL_MODE_BIT] = mode;
		return c;
	endfunction

	task automatic abort_run(input string why);
		$display("Result: FAILED");
		$fatal(1, "%s", why);
	endtask

	task automatic check_word(input string name, input logic [sbox_pkg::WORD_W-1:0] exp,
		input logic [sbox_pkg::WORD_W-1:0] act);
		if (exp !== act)
		begin
			$display("Error: %s expected %h actual %h", name, exp, act);
			abort_run("register value differs from the reference model");
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act)
		begin
			$display("Error: %s expected %h actual %h", name, exp, act);
			abort_run("status flag differs from the reference model");
		end
	endtask

	task automatic wait_ack;
		int waited;
		waited = 0;
		@(negedge clk);
		while (!ack && waited < ACK_LIMIT)
		begin
			@(negedge clk);
			waited++;
		end
		if (!ack)
			abort_run("no acknowledge from slave");
	endtask

	task automatic wb_write(input logic [sbox_pkg::ADDR_W-1:0] a,
		input logic [sbox_pkg::WORD_W-1:0] d, input logic [sbox_pkg::SBOX_LANES-1:0] s);
		@(negedge clk);
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b1;
		adr = a;
		dat_w = d;
		sel = s;
		wait_ack();
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic wb_read(input logic [sbox_pkg::ADDR_W-1:0] a,
		output logic [sbox_pkg::WORD_W-1:0] q);
		@(negedge clk);
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b0;
		adr = a;
		wait_ack();
		q = dat_r;
		cyc = 1'b0;
		stb = 1'b0;
	endtask

	// Done must already be set on the first poll after a DATA write
	task automatic poll_done;
		logic [sbox_pkg::WORD_W-1:0] q;
		wb_read(sbox_pkg::ADDR_STATUS, q);
		check_bit("status.done", 1'b1, q[sbox_pkg::STATUS_DONE_BIT]);
		check_bit("status.busy", 1'b0, q[sbox_pkg::STATUS_BUSY_BIT]);
	endtask

	task automatic transform(input logic mode, input logic [sbox_pkg::WORD_W-1:0] w,
		output logic [sbox_pkg::WORD_W-1:0] r);
		wb_write(sbox_pkg::ADDR_CTRL, mode_word(mode), ALL_LANES);
		wb_write(sbox_pkg::ADDR_DATA, w, ALL_LANES);
		poll_done();
		wb_read(sbox_pkg::ADDR_RESULT, r);
	endtask

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run("watchdog expired before the tests completed");
	end

	initial
	begin
		logic [sbox_pkg::WORD_W-1:0] q;
		logic [sbox_pkg::WORD_W-1:0] w;
		logic [sbox_pkg::WORD_W-1:0] r;
		logic [sbox_pkg::WORD_W-1:0] s0;
		logic [sbox_pkg::WORD_W-1:0] merged;
		logic [31:0] rnd;
		logic m;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		sel = '0;
		void'($urandom(SEED));
		@(negedge clk);
		while (reset)
			@(negedge clk);

		// Reset values
		wb_read(sbox_pkg::ADDR_CTRL, q);
		check_word("ctrl", mode_word(sbox_pkg::MODE_FWD), q);
		wb_read(sbox_pkg::ADDR_DATA, q);
		check_word("data", '0, q);
		wb_read(sbox_pkg::ADDR_RESULT, q);
		check_word("result", '0, q);
		wb_read(sbox_pkg::ADDR_STATUS, q);
		check_word("status", '0, q);

		// Known AES table entries
		transform(sbox_pkg::MODE_FWD, 32'h0053ff00, r);
		check_word("result", 32'h63ed1663, r);
		transform(sbox_pkg::MODE_INV, 32'h63636363, r);
		check_word("result", 32'h00000000, r);
		transform(sbox_pkg::MODE_INV, 32'h63ed1663, r);
		check_word("result", 32'h0053ff00, r);

		for (int n = 0; n < RANDOM_WORDS; n++)
		begin
			w = $urandom();
			rnd = $urandom();
			m = rnd[0];
			transform(m, w, r);
			check_word("result", expect_word(w, m), r);
		end

		for (int n = 0; n < ROUND_TRIPS; n++)
		begin
			w = $urandom();
			transform(sbox_pkg::MODE_FWD, w, r);
			transform(sbox_pkg::MODE_INV, r, q);
			check_word("round trip result", w, q);
		end

		// Byte selects on CTRL and DATA
		w = $urandom();
		transform(sbox_pkg::MODE_INV, w, r);
		check_word("result", expect_word(w, sbox_pkg::MODE_INV), r);
		wb_write(sbox_pkg::ADDR_CTRL, mode_word(sbox_pkg::MODE_FWD), 4'b1110);
		wb_read(sbox_pkg::ADDR_CTRL, q);
		check_word("ctrl", mode_word(sbox_pkg::MODE_INV), q);
		rnd = $urandom();
		wb_write(sbox_pkg::ADDR_DATA, rnd, 4'b0101);
		merged = {w[31:24], rnd[23:16], w[15:8], rnd[7:0]};
		poll_done();
		wb_read(sbox_pkg::ADDR_DATA, q);
		check_word("data", merged, q);
		wb_read(sbox_pkg::ADDR_RESULT, q);
		check_word("result", expect_word(merged, sbox_pkg::MODE_INV), q);

		// Read-only registers ignore writes
		r = expect_word(merged, sbox_pkg::MODE_INV);
		s0 = '0;
		s0[sbox_pkg::STATUS_DONE_BIT] = 1'b1;
		wb_write(sbox_pkg::ADDR_RESULT, ~r, ALL_LANES);
		wb_write(sbox_pkg::ADDR_STATUS, ~s0, ALL_LANES);
		wb_read(sbox_pkg::ADDR_RESULT, q);
		check_word("result", r, q);
		wb_read(sbox_pkg::ADDR_STATUS, q);
		check_word("status", s0, q);

		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- sbox_wb_top.f
verilog/sbox_pkg.sv
verilog/sbox_byte.sv
verilog/sbox_word.sv
verilog/wb_sbox_regs.sv
verilog/sbox_result.sv
verilog/sbox_wb_top.sv
dv/tb_clock.sv
dv/sbox_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= sbox_tb
FILELIST ?= sbox_wb_top.f
BUILD_DIR ?= obj_dir
SEED ?= 1
FLAGS ?= --binary --timing

SIM = $(BUILD_DIR)/V$(TOP)
SOURCES = $(wildcard verilog/*.sv dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) +verilator+seed+$(SEED)

clean:
	rm -rf $(BUILD_DIR)
